// File: verilog/debug_defines.svh
`ifndef DEBUG_DEFINES_SVH
`define DEBUG_DEFINES_SVH

// ########################################################################
// Serial link
// ########################################################################

// Clock cycles per serial bit, kept short for simulation
`define DBG_CLKS_PER_BIT 16

// ########################################################################
// Core and dump sizes
// ########################################################################

// Instruction words in the core memory
`define DBG_PROG_DEPTH 16

// Bytes per state dump: pc, r0..r3, retired
`define DBG_DUMP_LEN 6

`endif

// File: verilog/debug_pkg.sv
package debug_pkg;

	// Host command bytes (ASCII)
	typedef enum logic [7:0] {
		CMD_LOAD = 8'h4C,
		CMD_RUN  = 8'h52,
		CMD_STEP = 8'h53
	} cmd_t;

	// Instruction bits 7:6
	typedef enum logic [1:0] {
		OP_LDI  = 2'b00,
		OP_ADD  = 2'b01,
		OP_SUB  = 2'b10,
		OP_HALT = 2'b11
	} opcode_t;

	// r3 in the top byte, r0 in the bottom byte
	typedef logic [3:0][7:0] reg_file_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_COUNT,
		LOAD_DATA,
		RUN,
		STEP,
		DUMP_SEND,
		DUMP_WAIT
	} dbg_state_t;

endpackage

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
`include "debug_defines.svh"

module uart_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_done
);

	localparam int CW   = $clog2(`DBG_CLKS_PER_BIT);
	localparam int HALF = `DBG_CLKS_PER_BIT / 2 - 1;
	localparam int LAST = `DBG_CLKS_PER_BIT - 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} rx_state_t;

	rx_state_t     rx_state;
	logic          rx_meta;
	logic          rx_sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_idx;
	logic [7:0]    shift;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state <= S_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (rx_state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						rx_state <= S_START;
				end
				// Recheck the start bit at its middle, glitches go back to idle
				S_START: begin
					if (clk_cnt == CW'(HALF)) begin
						clk_cnt  <= '0;
						bit_idx  <= '0;
						rx_state <= rx_sync ? S_IDLE : S_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (clk_cnt == CW'(LAST)) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7)
							rx_state <= S_STOP;
						else
							bit_idx <= bit_idx + 3'd1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				// Byte only counts with a valid stop bit
				S_STOP: begin
					if (clk_cnt == CW'(LAST)) begin
						rx_state <= S_IDLE;
						rx_done  <= rx_sync;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: rx_state <= S_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (rx_state == S_DATA && clk_cnt == CW'(LAST))
			shift <= {rx_sync, shift[7:1]};
	end

	assign rx_data = shift;

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/1ps
`include "debug_defines.svh"

module uart_tx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       tx_done
);

	localparam int CW   = $clog2(`DBG_CLKS_PER_BIT);
	localparam int LAST = `DBG_CLKS_PER_BIT - 1;

	logic          busy;
	logic [CW-1:0] clk_cnt;
	logic [3:0]    bit_idx;
	logic [9:0]    frame;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			tx      <= 1'b1;
			tx_done <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				tx <= 1'b1;
				if (tx_start) begin
					busy    <= 1'b1;
					tx      <= 1'b0;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (clk_cnt == CW'(LAST)) begin
				clk_cnt <= '0;
				// Stop bit done after ten bit periods
				if (bit_idx == 4'd9) begin
					busy    <= 1'b0;
					tx_done <= 1'b1;
					tx      <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					tx      <= frame[1];
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// Frame is stop, data LSB first, start; bit 0 is on the line
	always_ff @(posedge clk) begin
		if (!busy && tx_start)
			frame <= {1'b1, tx_data, 1'b0};
		else if (busy && clk_cnt == CW'(LAST))
			frame <= {1'b1, frame[9:1]};
	end

endmodule

// File: verilog/mini_core.sv
`timescale 1ns/1ps
`include "debug_defines.svh"

module mini_core (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  core_clear,
	input  logic                  run_en,
	input  logic                  step,
	input  logic                  prog_we,
	input  logic [3:0]            prog_addr,
	input  logic [7:0]            prog_data,
	output logic [3:0]            pc,
	output debug_pkg::reg_file_t  regs,
	output logic [7:0]            retired,
	output logic                  halted
);

	logic [7:0]        imem [`DBG_PROG_DEPTH];
	logic [7:0]        instr;
	debug_pkg::opcode_t op;
	logic [1:0]        rd;
	logic [1:0]        rs;
	logic [7:0]        rd_val;
	logic [7:0]        rs_val;
	logic [7:0]        result;
	logic              exec;

	// Program load port from the debug unit
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	// ########################################################################
	// Decode
	// ########################################################################

	assign instr = imem[pc];
	assign op    = debug_pkg::opcode_t'(instr[7:6]);
	assign rd    = instr[5:4];
	assign rs    = instr[1:0];
	assign exec  = (run_en || step) && !halted;

	always_comb begin
		rd_val = regs[rd];
		rs_val = regs[rs];
		case (op)
			debug_pkg::OP_LDI: result = {4'b0000, instr[3:0]};
			debug_pkg::OP_ADD: result = rd_val + rs_val;
			debug_pkg::OP_SUB: result = rd_val - rs_val;
			default:           result = rd_val;
		endcase
	end

	// ########################################################################
	// Architectural state
	// ########################################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= '0;
			regs    <= '0;
			retired <= '0;
			halted  <= 1'b0;
		end else if (core_clear) begin
			pc      <= '0;
			regs    <= '0;
			retired <= '0;
			halted  <= 1'b0;
		end else if (exec) begin
			// HALT keeps the PC and is not counted
			if (op == debug_pkg::OP_HALT) begin
				halted <= 1'b1;
			end else begin
				regs[rd] <= result;
				pc       <= pc + 4'd1;
				retired  <= retired + 8'd1;
			end
		end
	end

endmodule

// File: verilog/state_collector.sv
`timescale 1ns/1ps
`include "debug_defines.svh"

module state_collector (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 restart,
	input  logic                 next,
	input  logic [3:0]           pc,
	input  debug_pkg::reg_file_t regs,
	input  logic [7:0]           retired,
	output logic [7:0]           data,
	output logic                 last
);

	localparam int IW = $clog2(`DBG_DUMP_LEN);

	logic [IW-1:0] idx;
	logic [IW-1:0] idx_nxt;
	logic [7:0]    sel;

	assign idx_nxt = restart ? '0 : (next ? idx + 1'b1 : idx);

	// Dump order: pc, r0, r1, r2, r3, retired
	always_comb begin
		case (idx_nxt)
			IW'(0):  sel = {4'b0000, pc};
			IW'(1):  sel = regs[0];
			IW'(2):  sel = regs[1];
			IW'(3):  sel = regs[2];
			IW'(4):  sel = regs[3];
			IW'(5):  sel = retired;
			default: sel = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx  <= '0;
			last <= 1'b0;
		end else begin
			idx  <= idx_nxt;
			last <= (idx_nxt == IW'(`DBG_DUMP_LEN - 1));
		end
	end

	always_ff @(posedge clk)
		data <= sel;

endmodule

// File: verilog/debug_fsm.sv
`timescale 1ns/1ps
`include "debug_defines.svh"

module debug_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rx_done,
	input  logic                  tx_done,
	input  logic                  halted,
	input  logic                  col_last,
	input  logic [7:0]            rx_data,
	input  logic [7:0]            col_data,
	output logic                  tx_start,
	output logic [7:0]            tx_data,
	output logic                  core_clear,
	output logic                  run_en,
	output logic                  step,
	output logic                  prog_we,
	output logic [3:0]            prog_addr,
	output logic [7:0]            prog_data,
	output logic                  col_restart,
	output logic                  col_next,
	output debug_pkg::dbg_state_t state
);

	logic [7:0] load_left;
	logic       col_ready;

	// Collector byte is registered, so skip the cycle of restart or next
	assign col_ready = !col_restart && !col_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= debug_pkg::IDLE;
			tx_start    <= 1'b0;
			core_clear  <= 1'b0;
			run_en      <= 1'b0;
			step        <= 1'b0;
			prog_we     <= 1'b0;
			prog_addr   <= '0;
			col_restart <= 1'b0;
			col_next    <= 1'b0;
			load_left   <= '0;
		end else begin
			// Strobes last one cycle
			tx_start    <= 1'b0;
			core_clear  <= 1'b0;
			step        <= 1'b0;
			prog_we     <= 1'b0;
			col_restart <= 1'b0;
			col_next    <= 1'b0;

			// Advance the write address after each stored byte
			if (prog_we)
				prog_addr <= (prog_addr == 4'(`DBG_PROG_DEPTH - 1)) ? '0 : prog_addr + 4'd1;

			case (state)
				// ################################################################
				// Command decode, unknown bytes are dropped
				// ################################################################
				debug_pkg::IDLE: begin
					if (rx_done) begin
						case (rx_data)
							debug_pkg::CMD_LOAD: state <= debug_pkg::LOAD_COUNT;
							debug_pkg::CMD_RUN: begin
								run_en <= 1'b1;
								state  <= debug_pkg::RUN;
							end
							debug_pkg::CMD_STEP: begin
								step  <= 1'b1;
								state <= debug_pkg::STEP;
							end
							default: state <= debug_pkg::IDLE;
						endcase
					end
				end

				// ################################################################
				// Program load
				// ################################################################
				debug_pkg::LOAD_COUNT: begin
					if (rx_done) begin
						prog_addr <= '0;
						load_left <= rx_data;
						if (rx_data == 8'd0) begin
							core_clear <= 1'b1;
							state      <= debug_pkg::IDLE;
						end else begin
							state <= debug_pkg::LOAD_DATA;
						end
					end
				end
				debug_pkg::LOAD_DATA: begin
					if (rx_done) begin
						prog_we   <= 1'b1;
						load_left <= load_left - 8'd1;
						// Last byte, restart the core from a clean state
						if (load_left == 8'd1) begin
							core_clear <= 1'b1;
							state      <= debug_pkg::IDLE;
						end
					end
				end

				// ################################################################
				// Execution
				// ################################################################
				debug_pkg::RUN: begin
					if (halted) begin
						run_en      <= 1'b0;
						col_restart <= 1'b1;
						state       <= debug_pkg::DUMP_SEND;
					end
				end
				// Step pulse has retired by now
				debug_pkg::STEP: begin
					col_restart <= 1'b1;
					state       <= debug_pkg::DUMP_SEND;
				end

				// ################################################################
				// Dump, one byte per transmitter frame
				// ################################################################
				debug_pkg::DUMP_SEND: begin
					if (col_ready) begin
						tx_start <= 1'b1;
						state    <= debug_pkg::DUMP_WAIT;
					end
				end
				debug_pkg::DUMP_WAIT: begin
					if (tx_done) begin
						if (col_last) begin
							state <= debug_pkg::IDLE;
						end else begin
							col_next <= 1'b1;
							state    <= debug_pkg::DUMP_SEND;
						end
					end
				end
				default: state <= debug_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == debug_pkg::LOAD_DATA && rx_done)
			prog_data <= rx_data;
		if (state == debug_pkg::DUMP_SEND && col_ready)
			tx_data <= col_data;
	end

endmodule

// File: verilog/debug_top.sv
`timescale 1ns/1ps

module debug_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rx,
	output logic                  tx,
	output debug_pkg::dbg_state_t led_state,
	output logic                  halted
);

	logic [7:0]           rx_data;
	logic                 rx_done;
	logic [7:0]           tx_data;
	logic                 tx_start;
	logic                 tx_done;
	logic                 core_clear;
	logic                 run_en;
	logic                 step;
	logic                 prog_we;
	logic [3:0]           prog_addr;
	logic [7:0]           prog_data;
	logic [3:0]           pc;
	debug_pkg::reg_file_t regs;
	logic [7:0]           retired;
	logic                 col_restart;
	logic                 col_next;
	logic [7:0]           col_data;
	logic                 col_last;

	// Host link
	uart_rx u_uart_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_done  (tx_done)
	);

	debug_fsm u_debug_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_done     (rx_done),
		.tx_done     (tx_done),
		.halted      (halted),
		.col_last    (col_last),
		.rx_data     (rx_data),
		.col_data    (col_data),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.core_clear  (core_clear),
		.run_en      (run_en),
		.step        (step),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.col_restart (col_restart),
		.col_next    (col_next),
		.state       (led_state)
	);

	state_collector u_state_collector (
		.clk     (clk),
		.rst_n   (rst_n),
		.restart (col_restart),
		.next    (col_next),
		.pc      (pc),
		.regs    (regs),
		.retired (retired),
		.data    (col_data),
		.last    (col_last)
	);

	// Core under debug
	mini_core u_mini_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.core_clear (core_clear),
		.run_en     (run_en),
		.step       (step),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.pc         (pc),
		.regs       (regs),
		.retired    (retired),
		.halted     (halted)
	);

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

endmodule

// File: verif/debug_checker.sv
`timescale 1ns/1ps

module debug_checker (
	input logic clk,
	input logic rst_n,
	input logic tx,
	input logic tx_start,
	input logic tx_done,
	input logic run_en,
	input logic step
);

	int   fail_count = 0;
	logic tx_busy;

	// Transmitter busy from its start strobe until the cycle after tx_done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tx_busy <= 1'b0;
		else if (tx_start)
			tx_busy <= 1'b1;
		else if (tx_done)
			tx_busy <= 1'b0;
	end

	// ########################################################################
	// Serial link rules
	// ########################################################################

	tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
		else begin
			$error("tx dropped low while the transmitter was idle");
			fail_count++;
		end

	tx_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
		else begin
			$error("tx_start raised while the transmitter was busy");
			fail_count++;
		end

	// Core control
	run_step_apart: assert property (@(posedge clk) disable iff (!rst_n) !(step && run_en))
		else begin
			$error("step and run_en high in the same cycle");
			fail_count++;
		end

endmodule

// File: verif/debug_tb.sv
`timescale 1ns/1ps
`include "debug_defines.svh"

module debug_tb;

	localparam int CPB        = `DBG_CLKS_PER_BIT;
	localparam int DEPTH      = `DBG_PROG_DEPTH;
	localparam int DUMP       = `DBG_DUMP_LEN;
	localparam int FIX_LEN    = 8;
	localparam int STEP_LEN   = 6;
	localparam int N_STEPS    = 7;
	localparam int N_RANDOM   = 10;
	localparam int QUIET_BITS = 20;
	// Serial bytes in both directions over all tests
	localparam int TOTAL_BYTES = (3 + FIX_LEN + DUMP)
		+ (2 + STEP_LEN + N_STEPS * (1 + DUMP))
		+ N_RANDOM * (3 + DEPTH + DUMP)
		+ (3 + 2 + STEP_LEN + 2 * (1 + DUMP) + 1);
	localparam int LIMIT_NS = ((TOTAL_BYTES * 12 + 2 * QUIET_BITS) * CPB + 5000) * 10;

	// LDI r0 and r1 then ADD and SUB with wrap and HALT at address 7
	localparam logic [7:0] FIX_PROG [FIX_LEN] = '{
		8'h05, 8'h19, 8'h60, 8'h61, 8'hB1, 8'h40, 8'h92, 8'hC0
	};
	localparam logic [7:0] STEP_PROG [STEP_LEN] = '{
		8'h03, 8'h14, 8'h41, 8'h90, 8'h70, 8'hC0
	};

	logic                  clk;
	logic                  rst_n;
	logic                  rx;
	logic                  tx;
	debug_pkg::dbg_state_t led_state;
	logic                  halted;

	logic [7:0] model_mem [DEPTH];
	logic [7:0] got_q [$];
	logic [7:0] want_q [$];
	int         rx_count = 0;
	int         n_checked = 0;
	int         n_expected = 0;

	tb_clock u_clock (
		.clk (clk)
	);

	debug_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.tx        (tx),
		.led_state (led_state),
		.halted    (halted)
	);

	bind debug_top debug_checker u_checker (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx       (tx),
		.tx_start (tx_start),
		.tx_done  (tx_done),
		.run_en   (run_en),
		.step     (step)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
			abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, want));
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ########################################################################
	// Reference core with the dump packed pc first in the low byte
	// ########################################################################

	function automatic logic [47:0] ref_dump(input logic [7:0] mem [DEPTH], input int max_steps);
		logic [3:0]         pc;
		logic [7:0]         r [4];
		logic [7:0]         ret;
		logic [7:0]         ins;
		debug_pkg::opcode_t op;
		int                 i;
		pc  = '0;
		ret = '0;
		r   = '{default: 8'h00};
		for (i = 0; i < max_steps; i++) begin
			ins = mem[pc];
			op  = debug_pkg::opcode_t'(ins[7:6]);
			// HALT keeps the PC and does not retire
			if (op == debug_pkg::OP_HALT)
				break;
			case (op)
				debug_pkg::OP_LDI: r[ins[5:4]] = {4'h0, ins[3:0]};
				debug_pkg::OP_ADD: r[ins[5:4]] = r[ins[5:4]] + r[ins[1:0]];
				debug_pkg::OP_SUB: r[ins[5:4]] = r[ins[5:4]] - r[ins[1:0]];
				default: ;
			endcase
			pc  = pc + 4'd1;
			ret = ret + 8'd1;
		end
		return {ret, r[3], r[2], r[1], r[0], 4'h0, pc};
	endfunction

	// ########################################################################
	// Host side of the serial link
	// ########################################################################

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			#1 rx = frame[i];
			repeat (CPB - 1) @(posedge clk);
		end
	endtask

	task automatic send_load(input int n);
		int i;
		send_byte(debug_pkg::CMD_LOAD);
		send_byte(8'(n));
		for (i = 0; i < n; i++)
			send_byte(model_mem[i]);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("led_state", led_state, debug_pkg::IDLE);
	endtask

	task automatic expect_dump(input logic [47:0] d);
		int i;
		for (i = 0; i < DUMP; i++)
			want_q.push_back(d[8 * i +: 8]);
		n_expected += DUMP;
	endtask

	task automatic run_command(input logic [7:0] cmd, input logic [47:0] d);
		expect_dump(d);
		send_byte(cmd);
		wait (n_checked == n_expected);
	endtask

	// Sampled on the falling edge away from tx updates
	initial begin : receiver
		logic [7:0] b;
		int         i;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			if (tx === 1'b0) begin
				repeat (CPB / 2) @(negedge clk);
				if (tx !== 1'b0)
					abort_run("Start bit on tx did not last to its middle");
				for (i = 0; i < 8; i++) begin
					repeat (CPB) @(negedge clk);
					b[i] = tx;
				end
				repeat (CPB) @(negedge clk);
				if (tx !== 1'b1)
					abort_run("Stop bit on tx was not high");
				got_q.push_back(b);
				rx_count++;
			end
		end
	end

	initial begin : compare
		logic [7:0] got;
		logic [7:0] want;
		forever begin
			wait (rx_count > n_checked);
			got = got_q.pop_front();
			if (want_q.size() == 0)
				abort_run($sformatf("Reply byte 0x%0h arrived when no reply was due", got));
			want = want_q.pop_front();
			check_value($sformatf("tx_byte[%0d]", n_checked % DUMP), 32'(got), 32'(want));
			n_checked++;
		end
	end

	initial begin : assertion_watch
		wait (uut.u_checker.fail_count != 0);
		abort_run("A bound assertion on the DUT failed");
	end

	initial begin : watchdog
		#(LIMIT_NS);
		abort_run("Timeout while waiting for the DUT to finish the tests");
	end

	// ########################################################################
	// Stimulus
	// ########################################################################

	initial begin : stimulus
		logic [31:0] seed;
		int          i;
		int          k;
		rst_n = 1'b0;
		rx    = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;

		// Quiet link after reset
		for (i = 0; i < 3 * CPB; i++) begin
			@(negedge clk);
			check_value("tx", tx, 1);
			check_value("halted", halted, 0);
			check_value("led_state", led_state, debug_pkg::IDLE);
		end

		// Fixed program run to HALT
		for (i = 0; i < FIX_LEN; i++)
			model_mem[i] = FIX_PROG[i];
		send_load(FIX_LEN);
		run_command(debug_pkg::CMD_RUN, ref_dump(model_mem, 256));
		@(negedge clk);
		check_value("halted", halted, 1);

		// Single steps with the last ones at HALT
		for (i = 0; i < STEP_LEN; i++)
			model_mem[i] = STEP_PROG[i];
		send_load(STEP_LEN);
		for (k = 1; k <= N_STEPS; k++)
			run_command(debug_pkg::CMD_STEP, ref_dump(model_mem, k));

		// Random programs with HALT in the last word
		seed = 32'hb2d8_5786;
		for (k = 0; k < N_RANDOM; k++) begin
			for (i = 0; i < DEPTH - 1; i++) begin
				seed         = lcg_next(seed);
				model_mem[i] = seed[31:24];
			end
			model_mem[DEPTH - 1] = {debug_pkg::OP_HALT, 6'h00};
			send_load(DEPTH);
			run_command(debug_pkg::CMD_RUN, ref_dump(model_mem, 256));
		end

		// Unknown commands
		send_byte(8'h00);
		send_byte(8'h41);
		send_byte(8'hFF);
		repeat (QUIET_BITS * CPB) @(posedge clk);
		@(negedge clk);
		check_value("reply_count", rx_count, n_expected);
		check_value("led_state", led_state, debug_pkg::IDLE);

		// A run command in the middle of a dump is dropped
		for (i = 0; i < STEP_LEN; i++)
			model_mem[i] = STEP_PROG[i];
		send_load(STEP_LEN);
		expect_dump(ref_dump(model_mem, 1));
		send_byte(debug_pkg::CMD_STEP);
		wait (rx_count >= n_expected - DUMP + 1);
		send_byte(debug_pkg::CMD_RUN);
		wait (n_checked == n_expected);
		repeat (QUIET_BITS * CPB) @(posedge clk);
		@(negedge clk);
		check_value("reply_count", rx_count, n_expected);
		check_value("halted", halted, 0);
		run_command(debug_pkg::CMD_STEP, ref_dump(model_mem, 2));

		if (uut.u_checker.fail_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			abort_run("A bound assertion on the DUT failed");
		end
	end

endmodule

// File: files.f
+incdir+verilog
verilog/debug_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/mini_core.sv
verilog/state_collector.sv
verilog/debug_fsm.sv
verilog/debug_top.sv
verif/tb_clock.sv
verif/debug_checker.sv
verif/debug_tb.sv
